//--- bench_wrapper.f
verilog/bench_cfg_pkg.sv
verilog/bench_stream_pkg.sv
verilog/operand_bank.sv
verilog/elementwise_kernel.sv
verilog/checksum_fold.sv
verilog/bench_wrapper.sv
tests/bench_wrapper_tb.sv

//--- operands.mem
// one 32-bit hex word per line: operand A, then B, then C (16 words each)
// within an operand: dataset-major, then element, then lane (lane 0 first)
00000003
00000007
0000001b
00000102
000a0b0c
12345678
0000ff01
80000001
00000009
00000011
7fffffff
00000044
5a5a1234
00000abc
13572468
00000002
00000005
0000000b
00000100
000000ff
00000003
0000007f
89abcdef
00000010
00001000
00000006
00000002
9e3779b1
00000021
2468ace0
00000003
fffffffe
00000001
00000002
00000003
00000004
11111111
22222222
33333333
44444444
0f0f0f0f
f0f0f0f0
00000000
ffffffff
00abcdef
01010101
76543210
00000080

//--- run_sim.sh
#!/bin/sh
# build and run the bench_wrapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module bench_wrapper_tb -f bench_wrapper.f

out=$(./obj_dir/Vbench_wrapper_tb)
echo "$out"
if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- tests/bench_wrapper_tb.sv
`timescale 1ns/1ps

module bench_wrapper_tb;
    import bench_cfg_pkg::*;

    typedef struct packed {
        logic [data_width-1:0] alpha;
        logic [data_width-1:0] beta;
        logic [lane_count-1:0] lane_en;
        logic                  rand_coef;
    } test_row_t;

    localparam int row_num       = 8;
    localparam int start_timeout = 100;
    localparam int run_timeout   = 200;
    // fifo depth plus fold latency and a margin
    localparam int quiet_cycles  = credit_depth + 4;

    logic                  ap_clk;
    logic                  arst_n;
    logic                  ap_start;
    logic [data_width-1:0] alpha;
    logic [data_width-1:0] beta;
    logic [lane_count-1:0] lane_enable;
    logic                  ap_idle;
    logic                  ap_done;
    logic [3:0]            data_out;
    logic                  data_valid;

    logic [data_width-1:0] img [image_total_words];
    test_row_t             rows [row_num];
    string                 row_names [row_num];
    logic [31:0]           rng;
    int                    fails;
    int                    tests_ok;

    bench_wrapper i_dut (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_start(ap_start),
        .alpha(alpha), .beta(beta), .lane_enable(lane_enable),
        .ap_idle(ap_idle), .ap_done(ap_done),
        .data_out(data_out), .data_valid(data_valid)
    );

    always #4 ap_clk = ~ap_clk;

    // ##############################
    // reference model
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [3:0] expected_nibble(input int ds, input int elem,
                                                   input logic [31:0] a_coef,
                                                   input logic [31:0] b_coef,
                                                   input logic [lane_count-1:0] en);
        logic [7:0]  acc;
        logic [31:0] d;
        int          idx;
        acc = '0;
        for (int l = 0; l < lane_count; l++)
        begin
            // dataset-major, then element, then lane
            idx = ds * elem_per_lane * lane_count + elem * lane_count + l;
            d = a_coef * img[operand_a_base + idx] * img[operand_b_base + idx]
              + b_coef * img[operand_c_base + idx];
            if (en[l])
                acc = acc ^ d[31:24] ^ d[23:16] ^ d[15:8] ^ d[7:0];
        end
        return acc[7:4] ^ acc[3:0];
    endfunction

    task automatic set_row(input int idx, input string name, input logic [31:0] a_coef,
                           input logic [31:0] b_coef, input logic [lane_count-1:0] en,
                           input logic rnd);
        row_names[idx]      = name;
        rows[idx].alpha     = a_coef;
        rows[idx].beta      = b_coef;
        rows[idx].lane_en   = en;
        rows[idx].rand_coef = rnd;
    endtask

    // ##############################
    // one run per table row
    task automatic run_row(input int run_idx);
        test_row_t             row;
        string                 name;
        logic [data_width-1:0] a_coef;
        logic [data_width-1:0] b_coef;
        logic [3:0]            exp_nib;
        int                    ds;
        int                    exp_beats;
        int                    n_beats;
        int                    cycles;
        int                    errs_before;
        bit                    accepted;
        bit                    done_seen;

        row         = rows[run_idx];
        name        = row_names[run_idx];
        ds          = run_idx % dataset_num;
        exp_beats   = (row.lane_en != '0) ? elem_per_lane : 0;
        errs_before = fails;
        a_coef      = row.alpha;
        b_coef      = row.beta;
        if (row.rand_coef)
        begin
            rng    = lcg_step(rng);
            a_coef = rng;
            rng    = lcg_step(rng);
            b_coef = rng;
        end

        // hold start until the kernel leaves idle
        @(posedge ap_clk);
        ap_start    <= 1'b1;
        alpha       <= a_coef;
        beta        <= b_coef;
        lane_enable <= row.lane_en;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted && cycles < start_timeout)
        begin
            @(negedge ap_clk);
            cycles++;
            accepted = !ap_idle;
        end
        @(posedge ap_clk);
        ap_start <= 1'b0;
        assert (accepted)
        else
        begin
            $display("%s: start was not accepted within %0d cycles", name, start_timeout);
            fails++;
        end

        n_beats   = 0;
        done_seen = 1'b0;
        cycles    = 0;
        while (!(done_seen && n_beats >= exp_beats) && cycles < run_timeout)
        begin
            @(negedge ap_clk);
            cycles++;
            if (ap_done)
                done_seen = 1'b1;
            if (data_valid)
            begin
                if (n_beats < elem_per_lane)
                begin
                    exp_nib = expected_nibble(ds, n_beats, a_coef, b_coef, row.lane_en);
                    assert (data_out == exp_nib)
                    else
                    begin
                        $display("mismatch %s beat %0d expected %h actual %h",
                                 name, n_beats, exp_nib, data_out);
                        fails++;
                    end
                end
                n_beats++;
            end
        end
        assert (done_seen)
        else
        begin
            $display("%s: no ap_done within %0d cycles", name, run_timeout);
            fails++;
        end

        // late or extra beats
        repeat (quiet_cycles)
        begin
            @(negedge ap_clk);
            if (data_valid)
                n_beats++;
        end
        assert (n_beats == exp_beats)
        else
        begin
            $display("%s: expected %0d data beats but saw %0d", name, exp_beats, n_beats);
            fails++;
        end
        assert (ap_idle)
        else
        begin
            $display("%s: ap_idle did not return high after ap_done", name);
            fails++;
        end

        if (fails == errs_before)
        begin
            tests_ok++;
            $display("run %0d %s dataset %0d lanes %b: ok", run_idx, name, ds, row.lane_en);
        end
        else
        begin
            $display("run %0d %s dataset %0d lanes %b: %0d errors", run_idx, name, ds,
                     row.lane_en, fails - errs_before);
        end
    endtask

    // ##############################
    initial
    begin
        ap_clk      = 1'b0;
        arst_n      = 1'b0;
        ap_start    = 1'b0;
        alpha       = '0;
        beta        = '0;
        lane_enable = '0;
        fails       = 0;
        tests_ok    = 0;
        rng         = 32'd80259;
        $readmemh("operands.mem", img);

        // runs alternate datasets 0 and 1
        set_row(0, "both_lanes_ds0", 32'd3, 32'd5, 2'b11, 1'b0);
        set_row(1, "both_lanes_ds1", 32'd2, 32'd7, 2'b11, 1'b0);
        set_row(2, "lane0_only", 32'd1, 32'd1, 2'b01, 1'b0);
        set_row(3, "lane1_only", 32'hffff_fffd, 32'd9, 2'b10, 1'b0);
        set_row(4, "no_lanes", 32'd4, 32'd4, 2'b00, 1'b0);
        set_row(5, "random_both", 32'd0, 32'd0, 2'b11, 1'b1);
        set_row(6, "random_lane1", 32'd0, 32'd0, 2'b10, 1'b1);
        set_row(7, "random_both_b", 32'd0, 32'd0, 2'b11, 1'b1);

        repeat (16) @(posedge ap_clk);
        arst_n <= 1'b1;

        for (int r = 0; r < row_num; r++)
            run_row(r);

        $display("summary: %0d runs, %0d clean, %0d failed checks", row_num, tests_ok, fails);
        if (fails == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog/bench_cfg_pkg.sv
package bench_cfg_pkg;

    // ##############################
    // kernel geometry
    localparam int lane_count      = 2;
    localparam int elem_per_lane   = 4;
    localparam int data_width      = 32;
    localparam int lane_bytes      = data_width / 8;
    localparam int elem_addr_width = 2;

    // ##############################
    // dataset handling
    localparam int dataset_num       = 2;
    localparam int reload_interval   = 1;
    localparam int operand_num       = 3;
    localparam int image_words       = dataset_num * elem_per_lane * lane_count;
    localparam int image_total_words = operand_num * image_words;
    localparam int operand_a_base    = 0;
    localparam int operand_b_base    = image_words;
    localparam int operand_c_base    = 2 * image_words;
    localparam int rom_addr_width    = $clog2(image_total_words);
    localparam int dataset_idx_width = (dataset_num > 1) ? $clog2(dataset_num) : 1;
    localparam int run_cnt_width     = (reload_interval > 1) ? $clog2(reload_interval) : 1;
    localparam string image_file     = "operands.mem";

    // flow control between kernel and folder
    localparam int credit_depth    = 4;
    localparam int credit_width    = $clog2(credit_depth + 1);
    localparam int fifo_addr_width = $clog2(credit_depth);

endpackage

//--- verilog/bench_stream_pkg.sv
package bench_stream_pkg;

    import bench_cfg_pkg::*;

    // one element of every lane, lane 0 in the low word
    typedef struct packed {
        logic [lane_count-1:0][data_width-1:0] lane;
    } operand_pair_t;

    // result of one element step
    // lane_mask marks the lanes that carry a result
    typedef struct packed {
        logic [lane_count-1:0]                 lane_mask;
        logic [lane_count-1:0][data_width-1:0] lane;
    } result_beat_t;

endpackage

//--- verilog/bench_wrapper.sv
`timescale 1ns/1ps

module bench_wrapper (
    input  logic                                 ap_clk,
    input  logic                                 arst_n,
    input  logic                                 ap_start,
    input  logic [bench_cfg_pkg::data_width-1:0] alpha,
    input  logic [bench_cfg_pkg::data_width-1:0] beta,
    input  logic [bench_cfg_pkg::lane_count-1:0] lane_enable,
    output logic                                 ap_idle,
    output logic                                 ap_done,
    output logic [3:0]                           data_out,
    output logic                                 data_valid
);
    import bench_cfg_pkg::*;
    import bench_stream_pkg::*;

    logic                       rd_en;
    logic [elem_addr_width-1:0] rd_addr;
    operand_pair_t              a_pair;
    operand_pair_t              b_pair;
    operand_pair_t              c_pair;
    logic                       a_loaded;
    logic                       b_loaded;
    logic                       c_loaded;
    logic                       banks_loaded;
    result_beat_t               beat;
    logic                       beat_valid;
    logic                       credit_return;

    assign banks_loaded = a_loaded & b_loaded & c_loaded;

    // ##############################
    // operand banks
    operand_bank #(.rom_base(operand_a_base)) u_bank_a (
        .ap_clk(ap_clk), .arst_n(arst_n), .rd_en(rd_en), .rd_addr(rd_addr),
        .run_done(ap_done), .rd_data(a_pair), .loaded(a_loaded)
    );

    operand_bank #(.rom_base(operand_b_base)) u_bank_b (
        .ap_clk(ap_clk), .arst_n(arst_n), .rd_en(rd_en), .rd_addr(rd_addr),
        .run_done(ap_done), .rd_data(b_pair), .loaded(b_loaded)
    );

    operand_bank #(.rom_base(operand_c_base)) u_bank_c (
        .ap_clk(ap_clk), .arst_n(arst_n), .rd_en(rd_en), .rd_addr(rd_addr),
        .run_done(ap_done), .rd_data(c_pair), .loaded(c_loaded)
    );

    // ##############################
    // kernel and checksum
    elementwise_kernel u_kernel (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_start(ap_start),
        .alpha(alpha), .beta(beta), .lane_enable(lane_enable),
        .banks_loaded(banks_loaded), .rd_en(rd_en), .rd_addr(rd_addr),
        .a_pair(a_pair), .b_pair(b_pair), .c_pair(c_pair),
        .beat(beat), .beat_valid(beat_valid), .credit_return(credit_return),
        .ap_idle(ap_idle), .ap_done(ap_done)
    );

    checksum_fold u_fold (
        .ap_clk(ap_clk), .arst_n(arst_n), .beat(beat), .beat_valid(beat_valid),
        .credit_return(credit_return), .data_out(data_out), .data_valid(data_valid)
    );

endmodule

//--- verilog/checksum_fold.sv
`timescale 1ns/1ps

module checksum_fold (
    input  logic                          ap_clk,
    input  logic                          arst_n,
    input  bench_stream_pkg::result_beat_t beat,
    input  logic                          beat_valid,
    output logic                          credit_return,
    output logic [3:0]                    data_out,
    output logic                          data_valid
);
    import bench_cfg_pkg::*;
    import bench_stream_pkg::*;

    result_beat_t                fifo_mem [credit_depth];
    logic [fifo_addr_width-1:0]  wr_ptr;
    logic [fifo_addr_width-1:0]  rd_ptr;
    logic [credit_width-1:0]     fifo_cnt;
    logic                        pop;
    result_beat_t                head;
    logic [lane_count-1:0][7:0]  lane_xor;
    logic [lane_count-1:0][7:0]  x1;
    logic [lane_count-1:0]       v1;
    logic [7:0]                  x2_next;
    logic [7:0]                  x2;
    logic                        v2;

    // ##############################
    // beat FIFO, never full thanks to credits
    assign pop           = (fifo_cnt != '0);
    assign credit_return = pop;
    assign head          = fifo_mem[rd_ptr];

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end
        else
        begin
            if (beat_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            fifo_cnt <= fifo_cnt + credit_width'(beat_valid) - credit_width'(pop);
        end
    end

    always_ff @(posedge ap_clk)
    begin
        if (beat_valid)
            fifo_mem[wr_ptr] <= beat;
    end

    // stage 1, bytes of each lane
    always_comb
    begin
        for (int i = 0; i < lane_count; i++)
        begin
            lane_xor[i] = '0;
            for (int j = 0; j < lane_bytes; j++)
                lane_xor[i] = lane_xor[i] ^ head.lane[i][8*j +: 8];
        end
    end

    // stage 2, select one lane or xor both
    always_comb
    begin
        x2_next = '0;
        for (int i = 0; i < lane_count; i++)
            if (v1[i])
                x2_next = x2_next ^ x1[i];
    end

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            v1         <= '0;
            v2         <= 1'b0;
            data_valid <= 1'b0;
        end
        else
        begin
            v1         <= pop ? head.lane_mask : '0;
            v2         <= |v1;
            data_valid <= v2;
        end
    end

    // stage 3 folds the nibbles
    always_ff @(posedge ap_clk)
    begin
        x1       <= lane_xor;
        x2       <= x2_next;
        data_out <= x2[7:4] ^ x2[3:0];
    end

endmodule

//--- verilog/elementwise_kernel.sv
`timescale 1ns/1ps

module elementwise_kernel (
    input  logic                                      ap_clk,
    input  logic                                      arst_n,
    input  logic                                      ap_start,
    input  logic [bench_cfg_pkg::data_width-1:0]      alpha,
    input  logic [bench_cfg_pkg::data_width-1:0]      beta,
    input  logic [bench_cfg_pkg::lane_count-1:0]      lane_enable,
    input  logic                                      banks_loaded,
    output logic                                      rd_en,
    output logic [bench_cfg_pkg::elem_addr_width-1:0] rd_addr,
    input  bench_stream_pkg::operand_pair_t           a_pair,
    input  bench_stream_pkg::operand_pair_t           b_pair,
    input  bench_stream_pkg::operand_pair_t           c_pair,
    output bench_stream_pkg::result_beat_t            beat,
    output logic                                      beat_valid,
    input  logic                                      credit_return,
    output logic                                      ap_idle,
    output logic                                      ap_done
);
    import bench_cfg_pkg::*;
    import bench_stream_pkg::*;

    typedef enum logic [1:0] {st_idle, st_run, st_drain} state_t;

    state_t                     state;
    logic [data_width-1:0]      alpha_q;
    logic [data_width-1:0]      beta_q;
    logic [lane_count-1:0]      lane_en_q;
    logic [elem_addr_width-1:0] rd_idx;
    logic                       rd_q;
    logic                       stage_vld;
    logic [credit_width-1:0]    credit_cnt;
    logic [credit_width-1:0]    in_flight;
    logic                       send_on;
    logic                       can_issue;
    logic                       last_rd;
    logic                       start_ok;

    assign send_on   = |lane_en_q;
    // reads whose beats still hold no credit
    assign in_flight = credit_width'(beat_valid) + credit_width'(rd_q);
    assign can_issue = !send_on || (credit_cnt > in_flight);
    assign rd_en     = (state == st_run) && can_issue;
    assign rd_addr   = rd_idx;
    assign last_rd   = (rd_idx == elem_addr_width'(elem_per_lane - 1));
    // idle again one cycle after done, once the banks see run_done
    assign ap_idle   = (state == st_idle) && !ap_done;
    assign start_ok  = ap_start && ap_idle && banks_loaded;
    assign beat_valid = stage_vld && send_on;

    // ##############################
    // control FSM
    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= st_idle;
            rd_idx    <= '0;
            lane_en_q <= '0;
            ap_done   <= 1'b0;
        end
        else
        begin
            ap_done <= 1'b0;
            case (state)
                st_idle:
                    if (start_ok)
                    begin
                        state     <= st_run;
                        rd_idx    <= '0;
                        lane_en_q <= lane_enable;
                    end
                st_run:
                    if (rd_en)
                    begin
                        rd_idx <= rd_idx + 1'b1;
                        if (last_rd)
                            state <= st_drain;
                    end
                st_drain:
                    // last element sits in the compute stage
                    if (stage_vld && !rd_q)
                    begin
                        ap_done <= 1'b1;
                        state   <= st_idle;
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge ap_clk)
    begin
        if (start_ok)
        begin
            alpha_q <= alpha;
            beta_q  <= beta;
        end
    end

    // read return, compute stage and credits
    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_q       <= 1'b0;
            stage_vld  <= 1'b0;
            credit_cnt <= credit_width'(credit_depth);
        end
        else
        begin
            rd_q       <= rd_en;
            stage_vld  <= rd_q;
            credit_cnt <= credit_cnt - credit_width'(beat_valid) + credit_width'(credit_return);
        end
    end

    // d = alpha*a*b + beta*c, wrapping at data_width
    always_ff @(posedge ap_clk)
    begin
        if (rd_q)
        begin
            for (int i = 0; i < lane_count; i++)
                beat.lane[i] <= alpha_q * a_pair.lane[i] * b_pair.lane[i]
                              + beta_q * c_pair.lane[i];
            beat.lane_mask <= lane_en_q;
        end
    end

endmodule

//--- verilog/operand_bank.sv
`timescale 1ns/1ps

module operand_bank #(
    parameter int rom_base = 0
) (
    input  logic                                      ap_clk,
    input  logic                                      arst_n,
    input  logic                                      rd_en,
    input  logic [bench_cfg_pkg::elem_addr_width-1:0] rd_addr,
    input  logic                                      run_done,
    output bench_stream_pkg::operand_pair_t           rd_data,
    output logic                                      loaded
);
    import bench_cfg_pkg::*;
    import bench_stream_pkg::*;

    logic [data_width-1:0]        rom [image_total_words];
    operand_pair_t                work_ram [elem_per_lane];
    logic                         copying;
    logic [elem_addr_width-1:0]   copy_idx;
    logic [dataset_idx_width-1:0] ds_idx;
    logic [run_cnt_width-1:0]     run_cnt;
    logic [rom_addr_width-1:0]    pair_base;
    operand_pair_t                copy_pair;

    // whole image, only this operand's slice is addressed
    initial
    begin
        $readmemh(image_file, rom);
    end

    // dataset-major, then element, then lane
    assign pair_base = rom_addr_width'(rom_base)
        + rom_addr_width'(ds_idx) * rom_addr_width'(elem_per_lane * lane_count)
        + rom_addr_width'(copy_idx) * rom_addr_width'(lane_count);

    always_comb
    begin
        for (int i = 0; i < lane_count; i++)
            copy_pair.lane[i] = rom[pair_base + rom_addr_width'(i)];
    end

    assign loaded = ~copying;

    // ##############################
    // copy engine and dataset sequencer
    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            copying  <= 1'b1;
            copy_idx <= '0;
            ds_idx   <= '0;
            run_cnt  <= '0;
        end
        else if (copying)
        begin
            copy_idx <= copy_idx + 1'b1;
            if (copy_idx == elem_addr_width'(elem_per_lane - 1))
            begin
                copy_idx <= '0;
                copying  <= 1'b0;
            end
        end
        else if (run_done)
        begin
            if (run_cnt == run_cnt_width'(reload_interval - 1))
            begin
                run_cnt <= '0;
                copying <= 1'b1;
                // next dataset, wrapping back to the first
                if (ds_idx == dataset_idx_width'(dataset_num - 1))
                    ds_idx <= '0;
                else
                    ds_idx <= ds_idx + 1'b1;
            end
            else
            begin
                run_cnt <= run_cnt + 1'b1;
            end
        end
    end

    // working ram, one pair per cycle in, one pair per read out
    always_ff @(posedge ap_clk)
    begin
        if (copying)
            work_ram[copy_idx] <= copy_pair;
        if (rd_en)
            rd_data <= work_ram[rd_addr];
    end

endmodule
